//--- design/blank_crop.sv
// Shifted and forced blank generation with the registered display enable
module blank_crop (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  crop_pkg::raster_meas_t meas,
	input  crop_pkg::crop_margin_t margins,
	input  logic                   line_start,
	input  logic                   hs_n,
	output logic                   video_de
);
	import crop_pkg::*;

	logic [cnt_w-1:0] sh_open;
	logic [cnt_w-1:0] sh_close;
	logic [cnt_w-1:0] fh_close;
	logic [cnt_w-1:0] sv_open;
	logic [cnt_w-1:0] sv_close;
	logic [cnt_w-1:0] fv_close;

	logic shbl; // Shifted blanks follow the margins
	logic svbl;
	logic fhbl; // Forced blanks keep clear of the sync edges
	logic fvbl;

	// Compare points wrap with the counters
	assign sh_open  = meas.hend + margins.hbl_l - h_shift;
	assign sh_close = meas.hsta + margins.hbl_r - h_shift;
	assign fh_close = meas.hmax - h_force;
	assign sv_open  = meas.vend + margins.vbl_t - v_shift;
	assign sv_close = meas.vsta + margins.vbl_b - v_shift;
	assign fv_close = meas.vmax - v_force_bot;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			shbl     <= 1'b1;
			fhbl     <= 1'b1;
			svbl     <= 1'b1;
			fvbl     <= 1'b1;
			video_de <= 1'b0;
		end else begin
			if (meas.hcnt == sh_open)  shbl <= 1'b0;
			if (meas.hcnt == sh_close) shbl <= 1'b1;

			if (meas.hcnt == h_force)  fhbl <= 1'b0;
			if (meas.hcnt == fh_close) fhbl <= 1'b1;

			// Vertical blanks only move at the start of a line
			if (line_start) begin
				if (meas.vcnt == sv_open)     svbl <= 1'b0;
				if (meas.vcnt == sv_close)    svbl <= 1'b1;
				if (meas.vcnt == v_force_top) fvbl <= 1'b0;
				if (meas.vcnt == fv_close)    fvbl <= 1'b1;
			end

			video_de <= hs_n & ~(shbl | fhbl | svbl | fvbl);
		end
	end

	a_de_sync: assert property (
		@(posedge clk_sys) disable iff (reset)
		!hs_n |=> !video_de
	) else $error("Display enable active during hsync");

endmodule

//--- design/crop_pkg.sv
// Counter widths, crop constants, key codes, adjust-side state and pipeline structs
package crop_pkg;

	localparam int cnt_w = 12; // Pixel and line counters
	localparam int flg_w = 7;
	localparam int res_w = 2;

	localparam logic [cnt_w-1:0] h_step      = 4; // Pixels per key press
	localparam logic [cnt_w-1:0] v_step      = 1;
	localparam logic [cnt_w-1:0] h_shift     = 2; // Compensates the pipeline delay
	localparam logic [cnt_w-1:0] v_shift     = 1;
	localparam logic [cnt_w-1:0] h_force     = 8;
	localparam logic [cnt_w-1:0] v_force_top = 1;
	localparam logic [cnt_w-1:0] v_force_bot = 3;

	localparam logic [1:0] kbd_kind_key = 2'd3;

	// Keyboard scan codes handled by the crop adjust
	typedef enum logic [7:0] {
		key_reset    = 8'h41, // Backspace
		key_up       = 8'h4c,
		key_down     = 8'h4d,
		key_right    = 8'h4e,
		key_left     = 8'h4f,
		key_alt_l    = 8'h64,
		key_alt_r    = 8'h65,
		key_alt_l_up = 8'he4, // Release codes
		key_alt_r_up = 8'he5
	} key_code_e;

	typedef enum logic {
		side_first,  // Top or left
		side_second  // Bottom or right
	} adj_side_e;

	typedef struct packed {
		logic hs_n;
		logic vs_n;
		logic hblank;
		logic vblank;
	} raster_in_t;

	typedef struct packed {
		logic       level; // Toggles on every event
		logic [1:0] kind;
		logic [7:0] code;
	} key_event_t;

	typedef struct packed {
		logic [cnt_w-1:0] hbl_l;
		logic [cnt_w-1:0] hbl_r;
		logic [cnt_w-1:0] vbl_t;
		logic [cnt_w-1:0] vbl_b;
	} crop_margin_t;

	typedef struct packed {
		logic [cnt_w-1:0] hcnt;
		logic [cnt_w-1:0] vcnt;
		logic [cnt_w-1:0] hsta;  // First blank pixel after active area
		logic [cnt_w-1:0] hend;  // First active pixel
		logic [cnt_w-1:0] hmax;
		logic [cnt_w-1:0] vsta;
		logic [cnt_w-1:0] vend;
		logic [cnt_w-1:0] vmax;
		logic [cnt_w-1:0] hsize;
		logic [cnt_w-1:0] vsize;
		logic             frame_start;
		logic             vblank_end;
	} raster_meas_t;

	typedef struct packed {
		crop_margin_t     margins;
		logic [cnt_w-1:0] hsize;
		logic [cnt_w-1:0] vsize;
		logic [res_w-1:0] res;
	} mode_info_t;

endpackage

//--- design/margin_keys.sv
// Keyboard decoder that steps the four crop margins with an alt side select
module margin_keys (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  crop_pkg::key_event_t   key,
	output crop_pkg::crop_margin_t margins
);
	import crop_pkg::*;

	logic      old_level;
	logic      key_hit;
	adj_side_e side;

	// New event when the level toggles on a key kind
	assign key_hit = (old_level ^ key.level) && (key.kind == kbd_kind_key);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_level <= 1'b0;
			side      <= side_first;
			margins   <= '0;
		end else begin
			old_level <= key.level;
			if (key_hit) begin
				case (key.code)
					key_reset: margins <= '0;
					key_up: begin
						if (side == side_second) margins.vbl_b <= margins.vbl_b + v_step;
						else                     margins.vbl_t <= margins.vbl_t + v_step;
					end
					key_down: begin
						if (side == side_second) margins.vbl_b <= margins.vbl_b - v_step;
						else                     margins.vbl_t <= margins.vbl_t - v_step;
					end
					key_left: begin
						if (side == side_second) margins.hbl_r <= margins.hbl_r + h_step;
						else                     margins.hbl_l <= margins.hbl_l + h_step;
					end
					key_right: begin
						if (side == side_second) margins.hbl_r <= margins.hbl_r - h_step;
						else                     margins.hbl_l <= margins.hbl_l - h_step;
					end
					key_alt_l, key_alt_r:       side <= side_second;
					key_alt_l_up, key_alt_r_up: side <= side_first;
					default: ; // Other keys ignored
				endcase
			end
		end
	end

	a_side_on_key: assert property (
		@(posedge clk_sys) disable iff (reset)
		!key_hit |=> $stable(side)
	) else $error("Adjust side moved without a key event");

endmodule

//--- design/mode_snapshot.sv
// Screen mode capture at end of vertical blank and mode change counter
module mode_snapshot (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  crop_pkg::raster_meas_t        meas,
	input  crop_pkg::crop_margin_t        margins,
	input  logic [crop_pkg::res_w-1:0]    res,
	output crop_pkg::mode_info_t          mode,
	output logic [crop_pkg::flg_w-1:0]    mode_flg
);

	logic mode_diff;

	// Compared against the previous snapshot
	assign mode_diff = (res != mode.res) ||
		(meas.hsize != mode.hsize) ||
		(meas.vsize != mode.vsize);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			mode     <= '0;
			mode_flg <= '0;
		end else if (meas.vblank_end) begin
			mode.margins <= margins;
			mode.hsize   <= meas.hsize;
			mode.vsize   <= meas.vsize;
			mode.res     <= res;
			if (mode_diff) mode_flg <= mode_flg + 1'b1; // Wraps at 128
		end
	end

	a_flg_on_vbl: assert property (
		@(posedge clk_sys) disable iff (reset)
		!meas.vblank_end |=> $stable(mode_flg)
	) else $error("mode_flg moved outside end of vblank");

endmodule

//--- design/raster_measure.sv
// Pixel and line counters with blank edge, line length and frame height capture
module raster_measure (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  crop_pkg::raster_in_t   raster,
	output crop_pkg::raster_meas_t meas,
	output logic                   line_start
);
	import crop_pkg::*;

	raster_in_t old; // Source levels one clock earlier

	logic hs_fall;
	logic vs_fall;
	logic hbl_fall;
	logic hbl_rise;
	logic vbl_fall;
	logic vbl_rise;

	assign hs_fall  = old.hs_n & ~raster.hs_n;
	assign vs_fall  = old.vs_n & ~raster.vs_n;
	assign hbl_fall = old.hblank & ~raster.hblank;
	assign hbl_rise = ~old.hblank & raster.hblank;
	assign vbl_fall = old.vblank & ~raster.vblank;
	assign vbl_rise = ~old.vblank & raster.vblank;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old        <= '0;
			line_start <= 1'b0;
		end else begin
			old        <= raster;
			line_start <= hs_fall;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			meas <= '0;
		end else begin
			// Horizontal
			meas.hcnt <= raster.hs_n ? meas.hcnt + 1'b1 : '0;
			if (hbl_fall) meas.hend <= meas.hcnt;
			if (hbl_rise) meas.hsta <= meas.hcnt;
			if (hs_fall)  meas.hmax <= meas.hcnt;

			// Width taken on one line just past the active area
			if (hbl_rise && meas.vcnt == meas.vsta + 1'b1)
				meas.hsize <= meas.hcnt - meas.hend;

			// Vertical
			if (hs_fall) meas.vcnt <= meas.vcnt + 1'b1;
			if (!raster.vs_n) meas.vcnt <= '0; // Held through vsync

			if (vbl_fall) meas.vend <= meas.vcnt;
			if (vbl_rise) meas.vsta <= meas.vcnt;
			if (vs_fall)  meas.vmax <= meas.vcnt;
			if (vbl_rise) meas.vsize <= meas.vcnt - meas.vend;

			meas.frame_start <= vs_fall;
			meas.vblank_end  <= vbl_fall;
		end
	end

	a_hcnt_clear: assert property (
		@(posedge clk_sys) disable iff (reset)
		!raster.hs_n |=> meas.hcnt == '0
	) else $error("hcnt not cleared after hsync");

endmodule

//--- design/video_crop.sv
// Video crop top with raster measure, margin keys, blank crop and mode snapshot
module video_crop (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  crop_pkg::raster_in_t       raster,
	input  logic [crop_pkg::res_w-1:0] res,
	input  crop_pkg::key_event_t       key,
	output logic                       video_de,
	output crop_pkg::mode_info_t       mode,
	output logic [crop_pkg::flg_w-1:0] mode_flg
);
	import crop_pkg::*;

	raster_meas_t meas;
	crop_margin_t margins;
	logic         line_start;

	raster_measure i_raster_measure (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.raster     (raster),
		.meas       (meas),
		.line_start (line_start)
	);

	margin_keys i_margin_keys (
		.clk_sys (clk_sys),
		.reset   (reset),
		.key     (key),
		.margins (margins)
	);

	blank_crop i_blank_crop (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.meas       (meas),
		.margins    (margins),
		.line_start (line_start),
		.hs_n       (raster.hs_n), // Straight from the source
		.video_de   (video_de)
	);

	mode_snapshot i_mode_snapshot (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.meas     (meas),
		.margins  (margins),
		.res      (res),
		.mode     (mode),
		.mode_flg (mode_flg)
	);

endmodule

//--- dv/video_crop_tb.sv
// Testbench with raster generator, key event table, crop and snapshot checks and watchdog
module video_crop_tb;
	import crop_pkg::*;

	localparam int n_rows      = 9;
	localparam int n_lines     = 24;
	localparam int max_len     = 80;
	localparam int hs_len      = 4;  // Hsync low clocks
	localparam int act_h_first = 12;
	localparam int act_h_last  = 51;
	localparam int act_v_first = 3;
	localparam int act_v_last  = 20;
	localparam int mid_line    = 10;
	localparam int timeout     = n_rows * 3 * max_len * n_lines * 8 + 20000;

	logic               clk_sys;
	logic               reset;
	raster_in_t         raster;
	logic [res_w-1:0]   res;
	key_event_t         key;
	logic               video_de;
	mode_info_t         mode;
	logic [flg_w-1:0]   mode_flg;

	int errors;
	int line_len;
	int de_clocks_mid;
	int de_lines;

	string      row_name   [n_rows];
	int         row_nkeys  [n_rows];
	logic [7:0] row_keys   [n_rows][4];
	logic [1:0] row_kind   [n_rows];
	logic [1:0] row_res    [n_rows];
	int         row_len    [n_rows];
	int         row_hsize  [n_rows];
	int         row_vsize  [n_rows];
	int         row_marg   [n_rows][4]; // hbl_l, hbl_r, vbl_t, vbl_b
	int         row_flg    [n_rows];

	video_crop i_video_crop (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.raster   (raster),
		.res      (res),
		.key      (key),
		.video_de (video_de),
		.mode     (mode),
		.mode_flg (mode_flg)
	);

	initial clk_sys = 1'b0;
	always #4 clk_sys = ~clk_sys;

	// Pixel counter value present while position p of a line is applied
	function automatic int hcnt_at(int p);
		return (p <= hs_len) ? 0 : p - hs_len;
	endfunction

	// DE clocks on an open line, from the shifted and forced horizontal blank rules
	function automatic int expect_de_clocks(int len, int l, int r);
		int hend;
		int hsta;
		int hmax;
		int sh_open;
		int sh_close;
		int fh_close;
		int c;
		int count;
		bit sh;
		bit fh;
		hend     = hcnt_at(act_h_first);
		hsta     = hcnt_at(act_h_last + 1);
		hmax     = len - hs_len;
		sh_open  = (hend + l - int'(h_shift)) & 'hfff;
		sh_close = (hsta + r - int'(h_shift)) & 'hfff;
		fh_close = (hmax - int'(h_force)) & 'hfff;
		sh       = 1'b1;
		fh       = 1'b1;
		count    = 0;
		for (int pass = 0; pass < 2; pass++) begin // First pass settles the flags
			for (int p = 0; p < len; p++) begin
				c = hcnt_at(p);
				if (pass == 1 && p >= hs_len && !sh && !fh) count++;
				if (c == sh_open) sh = 1'b0;
				if (c == sh_close) sh = 1'b1;
				if (c == int'(h_force)) fh = 1'b0;
				if (c == fh_close) fh = 1'b1;
			end
		end
		return count;
	endfunction

	// Lines with DE per frame, from the vertical blank rules at each line start
	function automatic int expect_de_lines(int t, int b);
		int vend;
		int vsta;
		int vmax;
		int sv_open;
		int sv_close;
		int fv_close;
		int count;
		bit sv;
		bit fv;
		vend     = act_v_first - 1;
		vsta     = act_v_last;
		vmax     = n_lines - 1;
		sv_open  = (vend + t - int'(v_shift)) & 'hfff;
		sv_close = (vsta + b - int'(v_shift)) & 'hfff;
		fv_close = (vmax - int'(v_force_bot)) & 'hfff;
		sv       = 1'b1;
		fv       = 1'b1;
		count    = 0;
		for (int pass = 0; pass < 2; pass++) begin
			for (int n = 0; n < n_lines; n++) begin
				if (n == sv_open) sv = 1'b0;
				if (n == sv_close) sv = 1'b1;
				if (n == int'(v_force_top)) fv = 1'b0;
				if (n == fv_close) fv = 1'b1;
				if (pass == 1 && !sv && !fv) count++;
			end
		end
		return count;
	endfunction

	task automatic set_row(int r, string name, int nk, logic [7:0] k0, logic [7:0] k1,
			logic [7:0] k2, logic [7:0] k3, logic [1:0] kind, logic [1:0] rs, int len,
			int hl, int hr, int vt, int vb, int flg);
		row_name[r]    = name;
		row_nkeys[r]   = nk;
		row_keys[r][0] = k0;
		row_keys[r][1] = k1;
		row_keys[r][2] = k2;
		row_keys[r][3] = k3;
		row_kind[r]    = kind;
		row_res[r]     = rs;
		row_len[r]     = len;
		row_hsize[r]   = act_h_last - act_h_first + 1;
		row_vsize[r]   = act_v_last - act_v_first + 1;
		row_marg[r][0] = hl;
		row_marg[r][1] = hr;
		row_marg[r][2] = vt;
		row_marg[r][3] = vb;
		row_flg[r]     = flg;
	endtask

	task automatic fill_table();
		set_row(0, "reset_state", 0, 8'h0, 8'h0, 8'h0, 8'h0, 2'd3, 2'd0, 64, 0, 0, 0, 0, 1);
		set_row(1, "left_up", 3, key_left, key_left, key_up, 8'h0, 2'd3, 2'd0, 64,
			8, 0, 1, 0, 1);
		set_row(2, "alt_wrap", 4, key_alt_l, key_right, key_down, key_alt_l_up, 2'd3, 2'd0,
			64, 8, 4092, 1, 4095, 1);
		set_row(3, "alt_release", 1, key_up, 8'h0, 8'h0, 8'h0, 2'd3, 2'd0, 64,
			8, 4092, 2, 4095, 1);
		set_row(4, "key_reset", 1, key_reset, 8'h0, 8'h0, 8'h0, 2'd3, 2'd0, 64, 0, 0, 0, 0, 1);
		set_row(5, "wrong_kind", 2, key_left, key_up, 8'h0, 8'h0, 2'd2, 2'd0, 64,
			0, 0, 0, 0, 1);
		set_row(6, "res_change", 0, 8'h0, 8'h0, 8'h0, 8'h0, 2'd3, 2'd1, 64, 0, 0, 0, 0, 2);
		set_row(7, "res_and_len", 0, 8'h0, 8'h0, 8'h0, 8'h0, 2'd3, 2'd2, 80, 0, 0, 0, 0, 3);
		set_row(8, "no_change", 0, 8'h0, 8'h0, 8'h0, 8'h0, 2'd3, 2'd2, 80, 0, 0, 0, 0, 3);
	endtask

	// Drives lines first..n_lines-1 of a frame, with optional keys and DE counting
	task automatic run_frame(int first, int row, bit with_keys, bit measure);
		int cnt;
		int k;
		if (measure) de_lines = 0;
		for (int n = first; n < n_lines; n++) begin
			cnt = 0;
			for (int p = 0; p < line_len; p++) begin
				@(negedge clk_sys);
				if (video_de) cnt++; // Output of the previous rising edge
				raster.hs_n   = (p >= hs_len);
				raster.hblank = !(p >= act_h_first && p <= act_h_last);
				raster.vs_n   = (n != 0);
				raster.vblank = !(n >= act_v_first && n <= act_v_last);
				k = n - 5;
				if (with_keys && p == 30 && k >= 0 && k < row_nkeys[row]) begin
					key.level = ~key.level;
					key.kind  = row_kind[row];
					key.code  = row_keys[row][k];
				end
			end
			if (measure) begin
				if (n == mid_line) de_clocks_mid = cnt;
				if (cnt > 0) de_lines++;
			end
		end
	endtask

	task automatic check_value(string test, string what, int expected, int actual);
		if (expected != actual) begin
			errors++;
			$display("ERROR %s %s expected %0d actual %0d", test, what, expected, actual);
		end
	endtask

	initial begin
		#(timeout);
		$display("Simulation timed out before all table rows were applied");
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		errors   = 0;
		line_len = 64;
		reset    = 1'b1;
		raster   = '0;
		res      = '0;
		key      = '0;
		fill_table();
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		// Start on the last blank line so a whole active area is measured before the first real snapshot
		run_frame(act_v_first - 1, 0, 1'b0, 1'b0);

		for (int r = 0; r < n_rows; r++) begin
			res      = row_res[r];
			line_len = row_len[r];
			run_frame(0, r, 1'b1, 1'b0);
			run_frame(0, r, 1'b0, 1'b0);
			run_frame(0, r, 1'b0, 1'b1);

			check_value(row_name[r], "hsize", row_hsize[r], int'(mode.hsize));
			check_value(row_name[r], "vsize", row_vsize[r], int'(mode.vsize));
			check_value(row_name[r], "res", int'(row_res[r]), int'(mode.res));
			check_value(row_name[r], "hbl_l", row_marg[r][0], int'(mode.margins.hbl_l));
			check_value(row_name[r], "hbl_r", row_marg[r][1], int'(mode.margins.hbl_r));
			check_value(row_name[r], "vbl_t", row_marg[r][2], int'(mode.margins.vbl_t));
			check_value(row_name[r], "vbl_b", row_marg[r][3], int'(mode.margins.vbl_b));
			check_value(row_name[r], "mode_flg", row_flg[r], int'(mode_flg));
			check_value(row_name[r], "de_clocks",
				expect_de_clocks(row_len[r], row_marg[r][0], row_marg[r][1]), de_clocks_mid);
			check_value(row_name[r], "de_lines",
				expect_de_lines(row_marg[r][2], row_marg[r][3]), de_lines);
		end

		$display("Checks done, errors %0d", errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the video crop testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module video_crop_tb \
	-f video_crop.f -o video_crop_sim > build.log 2>&1 \
	&& ./obj_dir/video_crop_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

//--- video_crop.f
design/crop_pkg.sv
design/raster_measure.sv
design/margin_keys.sv
design/blank_crop.sv
design/mode_snapshot.sv
design/video_crop.sv
dv/video_crop_tb.sv
